// ==== list.f ====
src/video_pkg.sv
src/video_if.sv
src/osd_mixer.sv
src/tx_launch_pipe.sv
src/extra_out_encoder.sv
src/video_out_top.sv
dv/tb_video_out.sv

// ==== Bender.yml ====
package:
  name: video_out

sources:
  - src/video_pkg.sv
  - src/video_if.sv
  - src/osd_mixer.sv
  - src/tx_launch_pipe.sv
  - src/extra_out_encoder.sv
  - src/video_out_top.sv
  - target: test
    files:
      - dv/tb_video_out.sv

// ==== dv/tb_video_out.sv ====
`timescale 1ns/1ps

module tb_video_out;
    import video_pkg::*;

    localparam int PIPE_DEPTH = 2;
    localparam int HDMI_LAT = 1 + PIPE_DEPTH;
    localparam int RESET_CYC = 4;
    localparam int T1_LEN = 10;
    localparam int T2_LEN = 60;
    localparam int T3_LEN = 40;
    localparam int T4_LEN = 60;
    localparam int T5_LEN = 40;
    localparam int T6_HOLD = 20;
    localparam int T6_RUN = 40;
    localparam int RUN_CYC = RESET_CYC + T1_LEN + T2_LEN + T3_LEN + T4_LEN + 3 * T5_LEN
                             + T6_HOLD + T6_RUN + 2;
    localparam int TIMEOUT_CYC = RUN_CYC + 50;
    localparam int HIST_LEN = 1024;

    logic pclk_out;
    logic po_reset_n;
    logic osd_enable_i;
    logic [OSD_COLOR_W-1:0] osd_color_i;
    logic [COLOR_W-1:0] sc_r_i;
    logic [COLOR_W-1:0] sc_g_i;
    logic [COLOR_W-1:0] sc_b_i;
    logic sc_hsync_i;
    logic sc_vsync_i;
    logic sc_de_i;
    logic extra_out_en_i;
    logic [XOUT_MODE_W-1:0] extra_out_mode_i;
    logic [COLOR_W-1:0] hdmitx_r_o;
    logic [COLOR_W-1:0] hdmitx_g_o;
    logic [COLOR_W-1:0] hdmitx_b_o;
    logic hdmitx_hsync_o;
    logic hdmitx_vsync_o;
    logic hdmitx_de_o;
    logic [COLOR_W-1:0] vga_r_o;
    logic [COLOR_W-1:0] vga_g_o;
    logic [COLOR_W-1:0] vga_b_o;
    logic vga_hs_o;
    logic vga_vs_o;
    logic vga_blank_n_o;
    logic vga_sync_n_o;

    // Stimulus history indexed by the driving rising edge
    logic [PIX_W-1:0] pix_h [HIST_LEN];
    logic [2:0] syn_h [HIST_LEN];
    logic osd_h [HIST_LEN];
    logic [OSD_COLOR_W-1:0] col_h [HIST_LEN];
    logic rst_h [HIST_LEN];
    logic en_h [HIST_LEN];
    logic [XOUT_MODE_W-1:0] mode_h [HIST_LEN];

    integer seed;
    int cyc;
    int tick_count;
    int err_count;
    int test_num;
    int test_fail;
    int test_err_base;
    logic running;
    logic [PIX_W+3:0] exp_pre;
    logic [PIX_W+3:0] exp_out;
    logic [PIX_W+3:0] vga_snap;

    video_out_top #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) uut (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .osd_enable_i     (osd_enable_i),
        .osd_color_i      (osd_color_i),
        .sc_r_i           (sc_r_i),
        .sc_g_i           (sc_g_i),
        .sc_b_i           (sc_b_i),
        .sc_hsync_i       (sc_hsync_i),
        .sc_vsync_i       (sc_vsync_i),
        .sc_de_i          (sc_de_i),
        .extra_out_en_i   (extra_out_en_i),
        .extra_out_mode_i (extra_out_mode_i),
        .hdmitx_r_o       (hdmitx_r_o),
        .hdmitx_g_o       (hdmitx_g_o),
        .hdmitx_b_o       (hdmitx_b_o),
        .hdmitx_hsync_o   (hdmitx_hsync_o),
        .hdmitx_vsync_o   (hdmitx_vsync_o),
        .hdmitx_de_o      (hdmitx_de_o),
        .vga_r_o          (vga_r_o),
        .vga_g_o          (vga_g_o),
        .vga_b_o          (vga_b_o),
        .vga_hs_o         (vga_hs_o),
        .vga_vs_o         (vga_vs_o),
        .vga_blank_n_o    (vga_blank_n_o),
        .vga_sync_n_o     (vga_sync_n_o)
    );

    initial begin
        pclk_out = 1'b0;
        forever #5 pclk_out = ~pclk_out;
    end

    // Expected HDMI word {r, g, b, hsync, vsync, de} for the sample driven at edge k
    function automatic logic [PIX_W+2:0] hdmi_expected(input int k);
        logic [PIX_W-1:0] pix;
        if (k < 0 || !rst_h[k]) begin
            return '0;
        end
        pix = pix_h[k];
        if (osd_h[k]) begin
            case (col_h[k])
                2'd0: pix = OSD_BLACK;
                2'd1: pix = OSD_BLUE;
                2'd2: pix = OSD_YELLOW;
                default: pix = OSD_WHITE;
            endcase
        end
        return {pix, syn_h[k]};
    endfunction

    // VGA word {r, g, b, hs, vs, blank_n, sync_n} for one HDMI word
    function automatic logic [PIX_W+3:0] vga_expected(input logic [PIX_W+2:0] hd,
                                                      input logic [XOUT_MODE_W-1:0] mode);
        logic cs;
        logic hs;
        logic vs;
        logic blank_n;
        logic sync_n;
        cs = (hd[2] == hd[1]);
        hs = (mode == XOUT_RGBHV) ? hd[2] : cs;
        vs = (mode == XOUT_RGBHV) ? hd[1] : 1'b1;
        blank_n = (mode == XOUT_YPBPR) ? 1'b1 : hd[0];
        sync_n = (mode == XOUT_RGSB || mode == XOUT_YPBPR) ? cs : 1'b0;
        return {hd[PIX_W+2:3], hs, vs, blank_n, sync_n};
    endfunction

    task automatic check_field(input string name, input logic [COLOR_W-1:0] exp_v,
                               input logic [COLOR_W-1:0] act_v);
        if (act_v !== exp_v) begin
            err_count++;
            $display("CHECK FAILED cycle %0d: %s expected %h, got %h", cyc, name, exp_v, act_v);
        end
    endtask

    task automatic compare_hdmi(input logic [PIX_W+2:0] exp_v);
        check_field("hdmitx_r_o", exp_v[PIX_W+2 -: COLOR_W], hdmitx_r_o);
        check_field("hdmitx_g_o", exp_v[PIX_W+2-COLOR_W -: COLOR_W], hdmitx_g_o);
        check_field("hdmitx_b_o", exp_v[PIX_W+2-2*COLOR_W -: COLOR_W], hdmitx_b_o);
        check_field("hdmitx_hsync_o", exp_v[2], hdmitx_hsync_o);
        check_field("hdmitx_vsync_o", exp_v[1], hdmitx_vsync_o);
        check_field("hdmitx_de_o", exp_v[0], hdmitx_de_o);
    endtask

    task automatic compare_vga(input logic [PIX_W+3:0] exp_v);
        check_field("vga_r_o", exp_v[PIX_W+3 -: COLOR_W], vga_r_o);
        check_field("vga_g_o", exp_v[PIX_W+3-COLOR_W -: COLOR_W], vga_g_o);
        check_field("vga_b_o", exp_v[PIX_W+3-2*COLOR_W -: COLOR_W], vga_b_o);
        check_field("vga_hs_o", exp_v[3], vga_hs_o);
        check_field("vga_vs_o", exp_v[2], vga_vs_o);
        check_field("vga_blank_n_o", exp_v[1], vga_blank_n_o);
        check_field("vga_sync_n_o", exp_v[0], vga_sync_n_o);
    endtask

    task automatic drive_cycle(input logic rst_v, input logic osd_v, input logic en_v,
                               input logic [XOUT_MODE_W-1:0] mode_v);
        logic [PIX_W-1:0] pix;
        logic [2:0] syn;
        @(posedge pclk_out);
        cyc++;
        pix = $random(seed);
        syn = $random(seed);
        po_reset_n <= rst_v;
        osd_enable_i <= osd_v;
        osd_color_i <= cyc[1:0];
        {sc_r_i, sc_g_i, sc_b_i} <= pix;
        {sc_hsync_i, sc_vsync_i, sc_de_i} <= syn;
        extra_out_en_i <= en_v;
        extra_out_mode_i <= mode_v;
        pix_h[cyc] = pix;
        syn_h[cyc] = syn;
        osd_h[cyc] = osd_v;
        col_h[cyc] = cyc[1:0];
        rst_h[cyc] = rst_v;
        en_h[cyc] = en_v;
        mode_h[cyc] = mode_v;
    endtask

    task automatic run_cycles(input int n, input logic osd_v, input logic en_v,
                              input logic [XOUT_MODE_W-1:0] mode_v);
        repeat (n) drive_cycle(1'b1, osd_v, en_v, mode_v);
    endtask

    task automatic start_test();
        test_num++;
        test_err_base = err_count;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = err_count - test_err_base;
        if (errs != 0) begin
            test_fail++;
        end
        $display("Test %0d %s: %s (%0d errors)", test_num, name, (errs == 0) ? "ok" : "bad", errs);
    endtask

    // Model the encoder stages and compare both outputs
    always @(negedge pclk_out) begin
        if (running && cyc > 0) begin
            if (!rst_h[cyc-1]) begin
                exp_pre = '0;
                exp_out = '0;
            end else if (en_h[cyc-1]) begin
                exp_out = exp_pre;
                exp_pre = vga_expected(hdmi_expected(cyc - HDMI_LAT - 1), mode_h[cyc-1]);
            end
            compare_hdmi(hdmi_expected(cyc - HDMI_LAT));
            compare_vga(exp_out);
        end
    end

    initial begin
        tick_count = 0;
        while (tick_count < TIMEOUT_CYC) begin
            @(posedge pclk_out);
            tick_count++;
        end
        $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYC);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed = 32'h82af_9577;
        cyc = 0;
        err_count = 0;
        test_num = 0;
        test_fail = 0;
        exp_pre = '0;
        exp_out = '0;
        po_reset_n <= 1'b0;
        osd_enable_i <= 1'b0;
        osd_color_i <= '0;
        sc_r_i <= '0;
        sc_g_i <= '0;
        sc_b_i <= '0;
        sc_hsync_i <= 1'b0;
        sc_vsync_i <= 1'b0;
        sc_de_i <= 1'b0;
        extra_out_en_i <= 1'b0;
        extra_out_mode_i <= XOUT_RGBHV;
        pix_h[0] = '0;
        syn_h[0] = '0;
        osd_h[0] = 1'b0;
        col_h[0] = '0;
        rst_h[0] = 1'b0;
        en_h[0] = 1'b0;
        mode_h[0] = XOUT_RGBHV;
        running = 1'b1;

        // Random inputs toggle during reset and must not leak out
        start_test();
        repeat (RESET_CYC - 1) drive_cycle(1'b0, 1'b0, 1'b1, XOUT_RGBHV);
        drive_cycle(1'b1, 1'b0, 1'b1, XOUT_RGBHV);
        @(negedge pclk_out);
        compare_hdmi('0);
        compare_vga('0);
        run_cycles(T1_LEN - 1, 1'b0, 1'b1, XOUT_RGBHV);
        finish_test("reset values");

        start_test();
        run_cycles(T2_LEN, 1'b0, 1'b1, XOUT_RGBHV);
        finish_test("hdmi pass-through");

        start_test();
        run_cycles(T3_LEN, 1'b1, 1'b1, XOUT_RGBHV);
        finish_test("osd colors");

        start_test();
        run_cycles(T4_LEN, 1'b0, 1'b1, XOUT_RGBHV);
        finish_test("vga rgbhv");

        start_test();
        run_cycles(T5_LEN, 1'b0, 1'b1, XOUT_RGBCS);
        run_cycles(T5_LEN, 1'b0, 1'b1, XOUT_RGSB);
        run_cycles(T5_LEN, 1'b0, 1'b1, XOUT_YPBPR);
        finish_test("vga composite modes");

        // Outputs frozen while deselected and across a mode change
        start_test();
        run_cycles(4, 1'b0, 1'b0, XOUT_RGSB);
        @(negedge pclk_out);
        vga_snap = exp_out;
        run_cycles(T6_HOLD - 4, 1'b0, 1'b0, XOUT_YPBPR);
        @(negedge pclk_out);
        compare_vga(vga_snap);
        run_cycles(T6_RUN, 1'b0, 1'b1, XOUT_RGSB);
        finish_test("vga hold");

        @(negedge pclk_out);
        #1;
        running = 1'b0;
        $display("Tests: %0d run, %0d failed, %0d check errors", test_num, test_fail, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== src/video_out_top.sv ====
`timescale 1ns/1ps

module video_out_top #(
    parameter int PIPE_DEPTH = 1
) (
    input  logic                              pclk_out,
    input  logic                              po_reset_n,

    // OSD generator
    input  logic                              osd_enable_i,
    input  logic [video_pkg::OSD_COLOR_W-1:0] osd_color_i,

    // Scaler output
    input  logic [video_pkg::COLOR_W-1:0]     sc_r_i,
    input  logic [video_pkg::COLOR_W-1:0]     sc_g_i,
    input  logic [video_pkg::COLOR_W-1:0]     sc_b_i,
    input  logic                              sc_hsync_i,
    input  logic                              sc_vsync_i,
    input  logic                              sc_de_i,

    // Extra output control
    input  logic                              extra_out_en_i,
    input  logic [video_pkg::XOUT_MODE_W-1:0] extra_out_mode_i,

    // HDMI transmitter
    output logic [video_pkg::COLOR_W-1:0]     hdmitx_r_o,
    output logic [video_pkg::COLOR_W-1:0]     hdmitx_g_o,
    output logic [video_pkg::COLOR_W-1:0]     hdmitx_b_o,
    output logic                              hdmitx_hsync_o,
    output logic                              hdmitx_vsync_o,
    output logic                              hdmitx_de_o,

    // VGA DAC
    output logic [video_pkg::COLOR_W-1:0]     vga_r_o,
    output logic [video_pkg::COLOR_W-1:0]     vga_g_o,
    output logic [video_pkg::COLOR_W-1:0]     vga_b_o,
    output logic                              vga_hs_o,
    output logic                              vga_vs_o,
    output logic                              vga_blank_n_o,
    output logic                              vga_sync_n_o
);

    video_if mix_bus ();
    video_if tx_bus ();

    osd_mixer u_osd_mixer (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .sc_r_i       (sc_r_i),
        .sc_g_i       (sc_g_i),
        .sc_b_i       (sc_b_i),
        .sc_hsync_i   (sc_hsync_i),
        .sc_vsync_i   (sc_vsync_i),
        .sc_de_i      (sc_de_i),
        .out_bus      (mix_bus.src)
    );

    tx_launch_pipe #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_tx_launch_pipe (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .in_bus     (mix_bus.snk),
        .out_bus    (tx_bus.src)
    );

    // HDMI pins come straight off the last launch stage
    assign hdmitx_r_o = tx_bus.r;
    assign hdmitx_g_o = tx_bus.g;
    assign hdmitx_b_o = tx_bus.b;
    assign hdmitx_hsync_o = tx_bus.hsync;
    assign hdmitx_vsync_o = tx_bus.vsync;
    assign hdmitx_de_o = tx_bus.de;

    extra_out_encoder u_extra_out_encoder (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .extra_out_en_i   (extra_out_en_i),
        .extra_out_mode_i (extra_out_mode_i),
        .in_bus           (tx_bus.snk),
        .vga_r_o          (vga_r_o),
        .vga_g_o          (vga_g_o),
        .vga_b_o          (vga_b_o),
        .vga_hs_o         (vga_hs_o),
        .vga_vs_o         (vga_vs_o),
        .vga_blank_n_o    (vga_blank_n_o),
        .vga_sync_n_o     (vga_sync_n_o)
    );

endmodule

// ==== src/extra_out_encoder.sv ====
`timescale 1ns/1ps

module extra_out_encoder (
    input  logic                              pclk_out,
    input  logic                              po_reset_n,

    input  logic                              extra_out_en_i,
    input  logic [video_pkg::XOUT_MODE_W-1:0] extra_out_mode_i,

    video_if.snk                              in_bus,

    output logic [video_pkg::COLOR_W-1:0]     vga_r_o,
    output logic [video_pkg::COLOR_W-1:0]     vga_g_o,
    output logic [video_pkg::COLOR_W-1:0]     vga_b_o,
    output logic                              vga_hs_o,
    output logic                              vga_vs_o,
    output logic                              vga_blank_n_o,
    output logic                              vga_sync_n_o
);
    import video_pkg::*;

    logic csync;
    logic hs_next;
    logic vs_next;
    logic blank_n_next;
    logic sync_n_next;

    logic [COLOR_W-1:0] pre_r;
    logic [COLOR_W-1:0] pre_g;
    logic [COLOR_W-1:0] pre_b;
    logic pre_hs;
    logic pre_vs;
    logic pre_blank_n;
    logic pre_sync_n;

    // Composite sync, high when hsync and vsync agree
    assign csync = ~(in_bus.hsync ^ in_bus.vsync);

    always_comb begin
        hs_next = csync;
        vs_next = 1'b1;
        blank_n_next = in_bus.de;
        sync_n_next = 1'b0;
        case (extra_out_mode_i)
            XOUT_RGBHV: begin
                hs_next = in_bus.hsync;
                vs_next = in_bus.vsync;
            end
            XOUT_RGSB: begin
                sync_n_next = csync;
            end
            XOUT_YPBPR: begin
                blank_n_next = 1'b1;
                sync_n_next = csync;
            end
            default: begin
                // RGBCS uses the defaults
            end
        endcase
    end

    // Both stages freeze while the extra output is deselected
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pre_r <= '0;
            pre_g <= '0;
            pre_b <= '0;
            pre_hs <= 1'b0;
            pre_vs <= 1'b0;
            pre_blank_n <= 1'b0;
            pre_sync_n <= 1'b0;
            vga_r_o <= '0;
            vga_g_o <= '0;
            vga_b_o <= '0;
            vga_hs_o <= 1'b0;
            vga_vs_o <= 1'b0;
            vga_blank_n_o <= 1'b0;
            vga_sync_n_o <= 1'b0;
        end else if (extra_out_en_i) begin
            pre_r <= in_bus.r;
            pre_g <= in_bus.g;
            pre_b <= in_bus.b;
            pre_hs <= hs_next;
            pre_vs <= vs_next;
            pre_blank_n <= blank_n_next;
            pre_sync_n <= sync_n_next;

            vga_r_o <= pre_r;
            vga_g_o <= pre_g;
            vga_b_o <= pre_b;
            vga_hs_o <= pre_hs;
            vga_vs_o <= pre_vs;
            vga_blank_n_o <= pre_blank_n;
            vga_sync_n_o <= pre_sync_n;
        end
    end

    // No sync on green in separate-sync modes, through both stages
    property p_no_sog_in_rgb;
        @(posedge pclk_out) disable iff (!po_reset_n)
            (extra_out_en_i && (extra_out_mode_i == XOUT_RGBHV ||
                                extra_out_mode_i == XOUT_RGBCS))
            ##1 extra_out_en_i |=> !vga_sync_n_o;
    endproperty

    a_no_sog_in_rgb: assert property (p_no_sog_in_rgb)
        else $error("extra_out_encoder: vga_sync_n_o high in RGBHV/RGBCS mode");

endmodule

// ==== src/tx_launch_pipe.sv ====
`timescale 1ns/1ps

module tx_launch_pipe #(
    parameter int PIPE_DEPTH = 1
) (
    input  logic pclk_out,
    input  logic po_reset_n,

    video_if.snk in_bus,
    video_if.src out_bus
);
    import video_pkg::*;

    // Pixel plus hsync, vsync, de
    localparam int STAGE_W = PIX_W + 3;

    logic [STAGE_W-1:0] stage_in;
    logic [STAGE_W-1:0] stage_q [PIPE_DEPTH];

    if (PIPE_DEPTH < 1) begin : g_depth_check
        $error("tx_launch_pipe: PIPE_DEPTH must be at least 1, got %0d", PIPE_DEPTH);
    end

    assign stage_in = {in_bus.r, in_bus.g, in_bus.b,
                       in_bus.hsync, in_bus.vsync, in_bus.de};

    // Launch registers toward the HDMI transmitter
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= stage_in;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign {out_bus.r, out_bus.g, out_bus.b,
            out_bus.hsync, out_bus.vsync, out_bus.de} = stage_q[PIPE_DEPTH-1];

endmodule

// ==== src/osd_mixer.sv ====
`timescale 1ns/1ps

module osd_mixer (
    input  logic                              pclk_out,
    input  logic                              po_reset_n,

    input  logic                              osd_enable_i,
    input  logic [video_pkg::OSD_COLOR_W-1:0] osd_color_i,

    input  logic [video_pkg::COLOR_W-1:0]     sc_r_i,
    input  logic [video_pkg::COLOR_W-1:0]     sc_g_i,
    input  logic [video_pkg::COLOR_W-1:0]     sc_b_i,
    input  logic                              sc_hsync_i,
    input  logic                              sc_vsync_i,
    input  logic                              sc_de_i,

    video_if.src                              out_bus
);
    import video_pkg::*;

    logic [PIX_W-1:0] osd_word;
    logic [PIX_W-1:0] mix_word;

    // Palette lookup
    always_comb begin
        case (osd_color_i)
            2'd0:    osd_word = OSD_BLACK;
            2'd1:    osd_word = OSD_BLUE;
            2'd2:    osd_word = OSD_YELLOW;
            default: osd_word = OSD_WHITE;
        endcase
    end

    assign mix_word = osd_enable_i ? osd_word : {sc_r_i, sc_g_i, sc_b_i};

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            out_bus.r <= '0;
            out_bus.g <= '0;
            out_bus.b <= '0;
            out_bus.hsync <= 1'b0;
            out_bus.vsync <= 1'b0;
            out_bus.de <= 1'b0;
        end else begin
            {out_bus.r, out_bus.g, out_bus.b} <= mix_word;

            // Syncs bypass the overlay
            out_bus.hsync <= sc_hsync_i;
            out_bus.vsync <= sc_vsync_i;
            out_bus.de <= sc_de_i;
        end
    end

    // OSD generator must present a defined index whenever it claims the pixel
    property p_osd_color_known;
        @(posedge pclk_out) disable iff (!po_reset_n)
            osd_enable_i |-> !$isunknown(osd_color_i);
    endproperty

    a_osd_color_known: assert property (p_osd_color_known)
        else $error("osd_mixer: osd_color_i unknown while OSD enabled");

endmodule

// ==== src/video_if.sv ====
`timescale 1ns/1ps

interface video_if;
    import video_pkg::*;

    // One pixel per pclk_out cycle, no handshake
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
    logic hsync;
    logic vsync;
    logic de;

    modport src (
        output r, g, b,
        output hsync, vsync, de
    );

    modport snk (
        input r, g, b,
        input hsync, vsync, de
    );

endinterface

// ==== src/video_pkg.sv ====
package video_pkg;

    // Pixel format
    localparam int COLOR_W = 8;
    localparam int PIX_W = 3 * COLOR_W;

    // OSD palette, index to {r, g, b}
    localparam int OSD_COLOR_W = 2;

    localparam logic [PIX_W-1:0] OSD_BLACK = 24'h00_00_00;
    localparam logic [PIX_W-1:0] OSD_BLUE = 24'h00_00_ff;
    localparam logic [PIX_W-1:0] OSD_YELLOW = 24'hff_ff_00;
    localparam logic [PIX_W-1:0] OSD_WHITE = 24'hff_ff_ff;

    // Extra (VGA DAC) output modes
    localparam int XOUT_MODE_W = 2;

    localparam logic [XOUT_MODE_W-1:0] XOUT_RGBHV = 2'd0;
    localparam logic [XOUT_MODE_W-1:0] XOUT_RGBCS = 2'd1;
    localparam logic [XOUT_MODE_W-1:0] XOUT_RGSB = 2'd2;
    localparam logic [XOUT_MODE_W-1:0] XOUT_YPBPR = 2'd3;

endpackage
